/* alu/rvj1_alu.sv */
// Single result register; a new request is taken only when that register is empty or draining
`default_nettype none

module rvj1_alu
  import rvj1_exec_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire alu_req_t req_i,
  input  wire logic     req_valid_i,
  output logic          pop_o,
  output alu_res_t      res_o,
  input  wire logic     res_ready_i,
  output logic          res_valid_o
);

  word_t      alu_value;
  logic [4:0] shamt;

  ////////////////////////////////////////
  // Comparators
  ////////////////////////////////////////

  // Signed less-than, sign bits decide when they differ
  function automatic logic lt_signed(input word_t a, input word_t b);
    logic lt;
    unique case ({a[$bits(word_t)-1], b[$bits(word_t)-1]})
      2'b10:   lt = 1'b1;
      2'b01:   lt = 1'b0;
      // Same sign, magnitude order is the unsigned order
      default: lt = (a < b);
    endcase
    return lt;
  endfunction

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////

  // RV32I shifts use only the low five bits
  assign shamt = req_i.op_b[4:0];

  always_comb
  begin
    unique case (req_i.op)
      ALU_OP_ADD:  alu_value = req_i.op_a + req_i.op_b;
      ALU_OP_SUB:  alu_value = req_i.op_a - req_i.op_b;
      ALU_OP_XOR:  alu_value = req_i.op_a ^ req_i.op_b;
      ALU_OP_OR:   alu_value = req_i.op_a | req_i.op_b;
      ALU_OP_AND:  alu_value = req_i.op_a & req_i.op_b;
      ALU_OP_SLL:  alu_value = req_i.op_a << shamt;
      ALU_OP_SRL:  alu_value = req_i.op_a >> shamt;
      ALU_OP_SRA:  alu_value = word_t'($signed(req_i.op_a) >>> shamt);
      ALU_OP_SLT:  alu_value = word_t'(lt_signed(req_i.op_a, req_i.op_b));
      ALU_OP_SLTU: alu_value = word_t'(req_i.op_a < req_i.op_b);
      default:     alu_value = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Take the head when the slot is free or leaving this cycle
  assign pop_o = req_valid_i && (!res_valid_o || res_ready_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      res_valid_o <= 1'b0;
    end
    else if (pop_o)
    begin
      res_valid_o <= 1'b1;
    end
    else if (res_ready_i)
    begin
      res_valid_o <= 1'b0;
    end
  end

  // Payload changes only on a new pop
  always_ff @(posedge clk_i)
  begin
    if (pop_o)
    begin
      res_o.rd    <= req_i.rd;
      res_o.value <= alu_value;
    end
  end

  // A stalled result stays put until writeback takes it
  res_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
    else $error("res_o changed under back-pressure: %h", res_o);

endmodule

`default_nettype wire

/* common/rvj1_exec_pkg.sv */
// Execute-stage types; queue depth must match the credit pool, and CREDIT_W must hold ISSUE_DEPTH
`default_nettype none

package rvj1_exec_pkg;
  import rvj1_isa_pkg::*;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  // Queue entries, also the decoder's starting credits
  localparam int ISSUE_DEPTH = 4;
  // Counts 0..ISSUE_DEPTH inclusive
  localparam int CREDIT_W = $clog2(ISSUE_DEPTH + 1);

  // Operand and result word
  typedef logic [XLEN-1:0] word_t;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'd0,
    ALU_OP_SUB  = 4'd1,
    ALU_OP_XOR  = 4'd2,
    ALU_OP_OR   = 4'd3,
    ALU_OP_AND  = 4'd4,
    ALU_OP_SLL  = 4'd5,
    ALU_OP_SRL  = 4'd6,
    ALU_OP_SRA  = 4'd7,
    ALU_OP_SLT  = 4'd8,
    ALU_OP_SLTU = 4'd9
  } alu_op_e;

  ////////////////////////////////////////
  // Request and result payloads
  ////////////////////////////////////////

  // Decoder to queue to ALU, 73 bits
  typedef struct packed {
    alu_op_e    op;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] rd;
  } alu_req_t;

  // ALU to writeback, 37 bits
  typedef struct packed {
    logic [4:0] rd;
    word_t      value;
  } alu_res_t;

endpackage

`default_nettype wire

/* common/rvj1_isa_pkg.sv */
// RV32I encodings for the OP and OP-IMM classes only; other opcodes are left to the decoder to drop
`default_nettype none

package rvj1_isa_pkg;

  ////////////////////////////////////////
  // Data width
  ////////////////////////////////////////

  localparam int XLEN = 32;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  // Register-register class
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // Register-immediate class
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  ////////////////////////////////////////
  // funct3 codes, shared by both classes
  ////////////////////////////////////////

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 for SUB and SRA, also imm[11:5] of SRAI
  // Only bit 5 differs from the base encoding
  localparam logic [6:0] F7_ALT = 7'b0100000;

  ////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////

  // R-type, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // I-type, imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // One word, two views
  // rd, funct3 and opcode sit at the same bits in both
  typedef union packed {
    rtype_t r;
    itype_t i;
  } instr_u;

endpackage

`default_nettype wire

/* hdl/rvj1_decoder.sv */
// Handles OP and OP-IMM only; other opcodes are consumed with no push, and funct7 is read for bit 5 only
`default_nettype none

module rvj1_decoder
  import rvj1_isa_pkg::*;
  import rvj1_exec_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            reset_i,
  input  wire logic            in_valid_i,
  output logic                 in_ready_o,
  input  wire instr_u          instr_i,
  input  wire logic [XLEN-1:0] rs1_val_i,
  input  wire logic [XLEN-1:0] rs2_val_i,
  input  wire logic            credit_i,
  output logic                 push_o,
  output alu_req_t             req_o
);

  logic [CREDIT_W-1:0] credits;
  logic                accept;
  logic                is_op;
  logic                is_op_imm;
  logic [2:0]          funct3;
  logic                alt;
  logic [XLEN-1:0]     imm_sext;
  alu_op_e             op;

  ////////////////////////////////////////
  // Handshake and push
  ////////////////////////////////////////

  // Free queue slots exist
  assign in_ready_o = (credits != '0);
  assign accept     = in_valid_i && in_ready_o;
  // Unsupported words are taken but never pushed
  assign push_o     = accept && (is_op || is_op_imm);

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  always_comb
  begin
    is_op     = (instr_i.r.opcode == OPC_OP);
    is_op_imm = (instr_i.i.opcode == OPC_OP_IMM);
    // funct3 sits at the same bits in both formats
    funct3    = instr_i.r.funct3;
    // Alternate bit is funct7[5], i.e. imm[10] for SRAI
    alt       = |(instr_i.r.funct7 & F7_ALT);
    imm_sext  = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    unique case (funct3)
      // No SUBI, alt only matters for OP
      F3_ADD_SUB: op = (is_op && alt) ? ALU_OP_SUB : ALU_OP_ADD;
      F3_SLL:     op = ALU_OP_SLL;
      F3_SLT:     op = ALU_OP_SLT;
      F3_SLTU:    op = ALU_OP_SLTU;
      F3_XOR:     op = ALU_OP_XOR;
      F3_SRL_SRA: op = alt ? ALU_OP_SRA : ALU_OP_SRL;
      F3_OR:      op = ALU_OP_OR;
      default:    op = ALU_OP_AND;
    endcase
  end

  // Shift amount is trimmed in the ALU, not here
  assign req_o.op   = op;
  assign req_o.op_a = rs1_val_i;
  assign req_o.op_b = is_op ? rs2_val_i : imm_sext;
  assign req_o.rd   = instr_i.r.rd;

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      credits <= CREDIT_W'(ISSUE_DEPTH);
    end
    else
    begin
      unique case ({push_o, credit_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Returned credits never outrun the queue size
  credit_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credits <= CREDIT_W'(ISSUE_DEPTH))
    else $error("credit count %0d above depth", credits);

endmodule

`default_nettype wire

/* hdl/rvj1_exec_top.sv */
// Execute stage, no register file or hazard logic; results leave in issue order over valid/ready
`default_nettype none

module rvj1_exec_top
  import rvj1_isa_pkg::*;
  import rvj1_exec_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            reset_i,
  input  wire logic            in_valid_i,
  output logic                 in_ready_o,
  input  wire instr_u          instr_i,
  input  wire logic [XLEN-1:0] rs1_val_i,
  input  wire logic [XLEN-1:0] rs2_val_i,
  input  wire logic            res_ready_i,
  output logic                 res_valid_o,
  output alu_res_t             res_o
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Decoder to queue
  logic     push;
  alu_req_t push_req;
  logic     credit;
  // Queue to ALU
  alu_req_t head_req;
  logic     head_valid;
  logic     pop;

  rvj1_decoder u_decoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .instr_i    (instr_i),
    .rs1_val_i  (rs1_val_i),
    .rs2_val_i  (rs2_val_i),
    .credit_i   (credit),
    .push_o     (push),
    .req_o      (push_req)
  );

  rvj1_issue_fifo u_issue_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (push),
    .req_i       (push_req),
    .pop_i       (pop),
    .head_o      (head_req),
    .not_empty_o (head_valid),
    .credit_o    (credit)
  );

  rvj1_alu u_alu (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (head_req),
    .req_valid_i (head_valid),
    .pop_o       (pop),
    .res_o       (res_o),
    .res_ready_i (res_ready_i),
    .res_valid_o (res_valid_o)
  );

endmodule

`default_nettype wire

/* hdl/rvj1_issue_fifo.sv */
// No full flag; the producer must hold a credit per push, and one credit goes back per pop
`default_nettype none

module rvj1_issue_fifo
  import rvj1_exec_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire logic     push_i,
  input  wire alu_req_t req_i,
  input  wire logic     pop_i,
  output alu_req_t      head_o,
  output logic          not_empty_o,
  output logic          credit_o
);

  alu_req_t                         mem [ISSUE_DEPTH];
  logic [$clog2(ISSUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(ISSUE_DEPTH)-1:0]   rd_ptr;
  logic [CREDIT_W-1:0]              count;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      mem[wr_ptr] <= req_i;
    end
  end

  // Head is visible the cycle after the push
  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (count != '0);
  // Each pop frees one slot upstream
  assign credit_o    = pop_i;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Wrap works for any depth
      if (push_i)
      begin
        wr_ptr <= (int'(wr_ptr) == ISSUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i)
      begin
        rd_ptr <= (int'(rd_ptr) == ISSUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      unique case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A push into a full queue means the decoder lost track of credits
  no_overflow_a: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (count < CREDIT_W'(ISSUE_DEPTH)))
    else $error("push into full queue, credit violation");

  // ALU must only pop a present head
  no_underflow_a: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> (count != '0))
    else $error("pop from empty queue");

endmodule

`default_nettype wire

/* list.f */
+incdir+verif
common/rvj1_isa_pkg.sv
common/rvj1_exec_pkg.sv
hdl/rvj1_decoder.sv
hdl/rvj1_issue_fifo.sv
alu/rvj1_alu.sv
hdl/rvj1_exec_top.sv
verif/rvj1_exec_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
# The log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module rvj1_exec_tb -Mdir "$OBJ" -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vrvj1_exec_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verif/rvj1_exec_ref.svh */
// Reference model for the execute stage; the including scope must import both rvj1 packages
`ifndef RVJ1_EXEC_REF_SVH
`define RVJ1_EXEC_REF_SVH

// R-type word from its fields
function automatic instr_u encode_rtype(input logic [6:0] funct7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] funct3,
                                        input logic [4:0] rd);
  instr_u w;
  w.r = {funct7, rs2, rs1, funct3, rd, OPC_OP};
  return w;
endfunction

// I-type word from its fields
function automatic instr_u encode_itype(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] funct3, input logic [4:0] rd);
  instr_u w;
  w.i = {imm12, rs1, funct3, rd, OPC_OP_IMM};
  return w;
endfunction

////////////////////////////////////////
// Expected writeback per the RV32I rules
////////////////////////////////////////

function automatic alu_res_t predict_result(input logic is_op, input logic [2:0] funct3,
                                            input logic alt, input word_t a,
                                            input word_t rs2_val, input logic [11:0] imm,
                                            input logic [4:0] rd);
  logic signed [31:0] simm;
  word_t              b;
  word_t              v;
  alu_res_t           res;
  // Immediate is always sign-extended
  simm = $signed(imm);
  b    = is_op ? rs2_val : word_t'(simm);
  case (funct3)
    // SUB exists only in the register form
    F3_ADD_SUB: v = (is_op && alt) ? (a - b) : (a + b);
    F3_SLL:     v = a << b[4:0];
    F3_SLT:     v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    F3_SLTU:    v = (a < b) ? 32'd1 : 32'd0;
    F3_XOR:     v = a ^ b;
    F3_SRL_SRA: v = alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
    F3_OR:      v = a | b;
    default:    v = a & b;
  endcase
  res.rd    = rd;
  res.value = v;
  return res;
endfunction

`endif

/* verif/rvj1_exec_tb.sv */
// Self-checking run of the execute stage; checks live in concurrent assertions, inputs change on negedge
`default_nettype none

module rvj1_exec_tb
  import rvj1_isa_pkg::*;
  import rvj1_exec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "rvj1_exec_ref.svh"

  localparam int RESET_CYCLES = 8;
  localparam int BP_STALL     = 12;
  localparam int N_RAND       = 150;
  localparam int MAX_GAP      = 3;
  // Words: back-pressure, directed R and I, comparisons, random mix
  localparam int STIM_CYCLES  = RESET_CYCLES + ISSUE_DEPTH + 2 + BP_STALL + 10 + 9 + 20
                                + N_RAND * (MAX_GAP + 1) + 20;
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

  // Mixed-sign comparison pairs
  localparam word_t CMP_A [5] = '{32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000,
                                  32'h7FFF_FFFF, 32'h0000_0005};
  localparam word_t CMP_B [5] = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                                  32'h8000_0000, 32'h0000_0005};

  logic     clk_i;
  logic     reset_i;
  logic     in_valid_i;
  logic     in_ready_o;
  instr_u   instr_i;
  word_t    rs1_val_i;
  word_t    rs2_val_i;
  logic     res_ready_i;
  logic     res_valid_o;
  alu_res_t res_o;

  // Scoreboard and stimulus side info
  alu_res_t    exp_q [$];
  alu_res_t    exp_head;
  int          exp_cnt;
  logic        stim_sup;
  alu_res_t    stim_pred;
  logic        bp_phase;
  int          bp_accepts;
  logic        final_check;
  logic        ready_random;
  int          errors;
  int          checked;
  int          cycles;
  logic [31:0] rng;

  rvj1_exec_top u_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .instr_i     (instr_i),
    .rs1_val_i   (rs1_val_i),
    .rs2_val_i   (rs2_val_i),
    .res_ready_i (res_ready_i),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////
  // Scoreboard and run limit
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (res_valid_o && res_ready_i && exp_q.size() != 0)
      begin
        void'(exp_q.pop_front());
        checked++;
      end
      if (in_valid_i && in_ready_o && stim_sup)
      begin
        exp_q.push_back(stim_pred);
      end
      if (bp_phase && in_valid_i && in_ready_o)
      begin
        bp_accepts++;
      end
    end
    // Seen by the assertions at the next edge
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d results still pending", cycles, exp_q.size());
      $display("errors %0d, results checked %0d", errors, checked);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  res_known_a: assert property (@(posedge clk_i) disable iff (reset_i)
    res_valid_o |-> (exp_cnt != 0))
    else
    begin
      errors++;
      $display("Unexpected result, res_valid_o high with nothing outstanding");
    end

  // Head of scoreboard must match in order
  res_value_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && exp_cnt != 0) |-> (res_o == exp_head))
    else
    begin
      errors++;
      $display("** Error res_o: got %h, expected %h", $sampled(res_o), $sampled(exp_head));
    end

  res_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
    else
    begin
      errors++;
      $display("** Error res_o: %h dropped or changed while stalled", $sampled(res_o));
    end

  // Idle pipeline, result shows two edges after acceptance
  latency_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_valid_i && in_ready_o && stim_sup && exp_cnt == 0 && !res_valid_o)
      |-> ##1 !res_valid_o ##1 res_valid_o)
    else
    begin
      errors++;
      $display("Result did not appear exactly 2 cycles after acceptance on an idle pipeline");
    end

  reset_state_a: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (!res_valid_o && in_ready_o))
    else
    begin
      errors++;
      $display("After reset res_valid_o should be low and in_ready_o high");
    end

  bp_fill_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (bp_phase && in_valid_i && bp_accepts < ISSUE_DEPTH + 1) |-> in_ready_o)
    else
    begin
      errors++;
      $display("in_ready_o fell after only %0d words under back-pressure", $sampled(bp_accepts));
    end

  bp_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (bp_phase && bp_accepts >= ISSUE_DEPTH + 1) |-> !in_ready_o)
    else
    begin
      errors++;
      $display("in_ready_o high again after ISSUE_DEPTH+1 words with res_ready_i low");
    end

  drain_a: assert property (@(posedge clk_i) disable iff (reset_i)
    final_check |-> (!u_dut.head_valid && !res_valid_o && exp_cnt == 0 && in_ready_o))
    else
    begin
      errors++;
      $display("Pipeline not empty at the end of the run");
    end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic step();
    @(negedge clk_i);
    if (ready_random)
    begin
      rng = xorshift32(rng);
      // Ready about three cycles in four
      res_ready_i = rng[0] | rng[1];
    end
  endtask

  task automatic next_rand(output word_t r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  task automatic present_word(input instr_u w, input word_t a, input word_t b,
                              input logic sup, input alu_res_t pred);
    instr_i    = w;
    rs1_val_i  = a;
    rs2_val_i  = b;
    stim_sup   = sup;
    stim_pred  = pred;
    in_valid_i = 1'b1;
  endtask

  // Accepting edge lies between the last check and the next negedge
  task automatic wait_accept();
    while (!in_ready_o)
    begin
      step();
    end
    step();
    in_valid_i = 1'b0;
  endtask

  task automatic send_alu(input logic is_op, input logic [2:0] f3, input logic alt,
                          input word_t a, input word_t b, input logic [11:0] imm,
                          input logic do_wait);
    logic [11:0] imm_enc;
    logic [6:0]  f7;
    logic [4:0]  rd;
    instr_u      w;
    rng     = xorshift32(rng);
    rd      = rng[4:0];
    f7      = alt ? F7_ALT : 7'b0;
    imm_enc = imm;
    // Shift immediates carry shamt and the alternate bit only
    if (!is_op && (f3 == F3_SLL || f3 == F3_SRL_SRA))
    begin
      imm_enc = {f7, imm[4:0]};
    end
    if (is_op)
    begin
      w = encode_rtype(f7, rng[9:5], rng[14:10], f3, rd);
    end
    else
    begin
      w = encode_itype(imm_enc, rng[14:10], f3, rd);
    end
    present_word(w, a, b, 1'b1, predict_result(is_op, f3, alt, a, b, imm_enc, rd));
    if (do_wait)
    begin
      wait_accept();
    end
  endtask

  task automatic send_random(input logic do_wait);
    logic       is_op;
    logic [2:0] f3;
    logic       alt;
    word_t      a;
    word_t      b;
    next_rand(a);
    next_rand(b);
    rng   = xorshift32(rng);
    is_op = rng[0];
    f3    = rng[3:1];
    // Alternate bit only where the ISA defines it
    alt   = rng[4] && (f3 == F3_SRL_SRA || (is_op && f3 == F3_ADD_SUB));
    send_alu(is_op, f3, alt, a, b, rng[27:16], do_wait);
  endtask

  task automatic send_unsupported();
    instr_u w;
    word_t  a;
    word_t  b;
    next_rand(a);
    next_rand(b);
    rng = xorshift32(rng);
    w   = rng;
    // Bit 4 flip moves OP and OP-IMM to STORE and LOAD
    if (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM)
    begin
      w.r.opcode = w.r.opcode ^ 7'b0010000;
    end
    present_word(w, a, b, 1'b0, '0);
    wait_accept();
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
    begin
      step();
    end
    repeat (2) step();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    word_t a;
    word_t b;
    int    gap;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    in_valid_i   = 1'b0;
    instr_i      = '0;
    rs1_val_i    = '0;
    rs2_val_i    = '0;
    res_ready_i  = 1'b0;
    stim_sup     = 1'b0;
    stim_pred    = '0;
    bp_phase     = 1'b0;
    bp_accepts   = 0;
    final_check  = 1'b0;
    ready_random = 1'b0;
    errors       = 0;
    checked      = 0;
    cycles       = 0;
    rng          = 32'd63;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;

    // Back-pressure from reset, one extra word left waiting
    bp_phase = 1'b1;
    for (int k = 0; k < ISSUE_DEPTH + 1; k++)
    begin
      send_random(1'b1);
    end
    send_random(1'b0);
    repeat (BP_STALL) step();
    bp_phase    = 1'b0;
    res_ready_i = 1'b1;
    wait_accept();
    drain();

    // Every R-type and I-type operation
    for (int f = 0; f < 8; f++)
    begin
      next_rand(a);
      next_rand(b);
      send_alu(1'b1, 3'(f), 1'b0, a, b, b[11:0], 1'b1);
    end
    next_rand(a);
    next_rand(b);
    send_alu(1'b1, F3_ADD_SUB, 1'b1, a, b, 12'h0, 1'b1);
    send_alu(1'b1, F3_SRL_SRA, 1'b1, a | 32'h8000_0000, b, 12'h0, 1'b1);
    for (int f = 0; f < 8; f++)
    begin
      next_rand(a);
      next_rand(b);
      send_alu(1'b0, 3'(f), 1'b0, a, b, b[23:12], 1'b1);
    end
    send_alu(1'b0, F3_SRL_SRA, 1'b1, a | 32'h8000_0000, b, b[11:0], 1'b1);

    // Signed versus unsigned compare
    for (int k = 0; k < 5; k++)
    begin
      send_alu(1'b1, F3_SLT, 1'b0, CMP_A[k], CMP_B[k], 12'h0, 1'b1);
      send_alu(1'b1, F3_SLTU, 1'b0, CMP_A[k], CMP_B[k], 12'h0, 1'b1);
      send_alu(1'b0, F3_SLT, 1'b0, CMP_A[k], 32'h0, CMP_B[k][11:0], 1'b1);
      send_alu(1'b0, F3_SLTU, 1'b0, CMP_A[k], 32'h0, CMP_B[k][11:0], 1'b1);
    end
    drain();

    // Random mix with gaps, unsupported words and random ready
    ready_random = 1'b1;
    for (int n = 0; n < N_RAND; n++)
    begin
      rng = xorshift32(rng);
      gap = int'(rng % 32'(MAX_GAP + 1));
      repeat (gap) step();
      rng = xorshift32(rng);
      if (rng[7:0] < 8'd40)
      begin
        send_unsupported();
      end
      else
      begin
        send_random(1'b1);
      end
    end
    ready_random = 1'b0;
    res_ready_i  = 1'b1;
    drain();
    final_check = 1'b1;
    step();
    final_check = 1'b0;
    step();

    $display("errors %0d, results checked %0d", errors, checked);
    if (errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
